/* common/asteroid_pkg.sv */
package asteroid_pkg;

	//////////////////////////////
	// Basic game types
	//////////////////////////////
	typedef logic [9:0] coord_t;          // Screen coordinate
	typedef logic signed [3:0] step_t;    // Jet step per frame, -4 to +4
	typedef logic [1:0] level_t;          // Game level 0..3
	typedef logic [7:0] score_t;          // Wrapping score
	typedef logic [3:0] bspeed_t;         // Bullet pixels per frame

	typedef enum logic [1:0]
	{
		PAUSE    = 2'd0,
		PLAY     = 2'd1,
		GAMEOVER = 2'd2
	} game_state_t;

	// Bullet speed window
	localparam bspeed_t BSPEED_MIN   = 4'd6;
	localparam bspeed_t BSPEED_MAX   = 4'd11;
	localparam bspeed_t BSPEED_RESET = 4'd7;

	// Jet start and move limits
	localparam coord_t JET_X_RESET = 10'd380;
	localparam coord_t JET_Y_RESET = 10'd430;
	localparam coord_t JET_X_MIN   = 10'd15;
	localparam coord_t JET_X_MAX   = 10'd625;
	localparam coord_t JET_Y_MIN   = 10'd5;
	localparam coord_t JET_Y_MAX   = 10'd450;

	// Asteroid and collision geometry
	localparam coord_t ASTEROID_FLOOR = 10'd510;
	localparam coord_t HIT_HALF_WIDTH = 10'd16;   // Half box width, both hit types
	localparam coord_t BULLET_REACH   = 10'd8;
	localparam coord_t JET_HIT_DEPTH  = 10'd20;

	// Spawn interval in frames, shrinks per level
	localparam int SPAWN_BASE = 100;
	localparam int SPAWN_STEP = 15;

	localparam coord_t LFSR_SEED = 10'h2A5;

endpackage

/* common/ctrl_if.sv */
interface ctrl_if
	import asteroid_pkg::*;
();

	// Player commands, decode side to world side
	logic    run;            // Level, high while PLAY is wanted
	logic    fire;           // One cycle pulse
	step_t   step_x;         // Joystick zone steps
	step_t   step_y;
	bspeed_t bullet_speed;   // Held in decode

	modport decode
	(
		output run,
		output fire,
		output step_x,
		output step_y,
		output bullet_speed
	);

	modport execute
	(
		input run,
		input fire,
		input step_x,
		input step_y,
		input bullet_speed
	);

endinterface

/* design/input_decode.sv */
module input_decode
	import asteroid_pkg::*;
(
	input  logic   DIV_CLK,
	input  logic   reset,
	input  logic   btn_fire_i,
	input  logic   btn_up_i,
	input  logic   btn_down_i,
	input  logic   btn_run_i,
	input  coord_t joy_x_i,
	input  coord_t joy_y_i,
	ctrl_if.decode ctrl
);

	logic [3:0] btn_now;
	logic [3:0] btn_q;       // Last sampled buttons
	logic [3:0] btn_rise;
	logic       run_q;
	logic       fire_q;
	bspeed_t    speed_q;

	// Bit order fire, up, down, run
	assign btn_now  = {btn_fire_i, btn_up_i, btn_down_i, btn_run_i};
	assign btn_rise = btn_now & ~btn_q;

	//////////////////////////////
	// Button edges
	//////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			btn_q   <= '0;
			run_q   <= 1'b0;
			fire_q  <= 1'b0;
			speed_q <= BSPEED_RESET;
		end
		else
		begin
			btn_q  <= btn_now;
			fire_q <= btn_rise[3];            // Single pulse per press
			if (btn_rise[0])
				run_q <= ~run_q;              // Start/stop toggle
			// Speed saturates at both ends
			if (btn_rise[2] && speed_q < BSPEED_MAX)
				speed_q <= speed_q + 4'd1;
			else if (btn_rise[1] && speed_q > BSPEED_MIN)
				speed_q <= speed_q - 4'd1;
		end
	end

	//////////////////////////////
	// Joystick zones
	//////////////////////////////
	always_comb
	begin
		// X reads high when pushed left
		if (joy_x_i > 10'd720)
			ctrl.step_x = -4'sd4;
		else if (joy_x_i > 10'd650)
			ctrl.step_x = -4'sd2;
		else if (joy_x_i > 10'd540)
			ctrl.step_x = -4'sd1;
		else if (joy_x_i < 10'd200)
			ctrl.step_x = 4'sd4;
		else if (joy_x_i <= 10'd330)
			ctrl.step_x = 4'sd2;
		else if (joy_x_i < 10'd440)
			ctrl.step_x = 4'sd1;
		else
			ctrl.step_x = 4'sd0;          // Dead zone

		if (joy_y_i > 10'd700)
			ctrl.step_y = 4'sd2;
		else if (joy_y_i >= 10'd540)
			ctrl.step_y = 4'sd1;
		else if (joy_y_i < 10'd300)
			ctrl.step_y = -4'sd2;
		else if (joy_y_i <= 10'd440)
			ctrl.step_y = -4'sd1;
		else
			ctrl.step_y = 4'sd0;
	end

	assign ctrl.run          = run_q;
	assign ctrl.fire         = fire_q;
	assign ctrl.bullet_speed = speed_q;

endmodule

/* game/asteroid_spawner.sv */
module asteroid_spawner
	import asteroid_pkg::*;
(
	input  logic   DIV_CLK,
	input  logic   reset,
	input  logic   frame_tick_i,
	input  logic   playing_i,
	input  level_t level_i,
	output logic   spawn_valid_o,
	output coord_t spawn_x_o
);

	coord_t     lfsr;
	logic       lfsr_fb;
	logic [6:0] frame_cnt;
	logic [6:0] spawn_thr;     // Frames between spawns

	// Taps 10 and 7
	assign lfsr_fb = lfsr[9] ^ lfsr[6];

	// 100, 85, 70, 55 frames for levels 0..3
	assign spawn_thr = 7'(SPAWN_BASE - int'(level_i) * SPAWN_STEP);

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			lfsr          <= LFSR_SEED;
			frame_cnt     <= '0;
			spawn_valid_o <= 1'b0;
		end
		else
		begin
			spawn_valid_o <= 1'b0;            // Pulse only
			if (frame_tick_i)
			begin
				lfsr <= {lfsr[8:0], lfsr_fb};  // Free runs in every state
				if (playing_i)
				begin
					if (frame_cnt >= spawn_thr - 7'd1)
					begin
						spawn_valid_o <= 1'b1;
						frame_cnt     <= '0;
					end
					else
						frame_cnt <= frame_cnt + 7'd1;
				end
			end
		end
	end

	// Column from the pre-step LFSR value, kept on screen
	always_ff @(posedge DIV_CLK)
	begin
		if (frame_tick_i && playing_i)
			spawn_x_o <= (lfsr > 10'd620) ? (lfsr >> 1) : (lfsr + 10'd20);
	end

endmodule

/* game/world_update.sv */
module world_update
	import asteroid_pkg::*;
#(
	parameter int NUM_SLOTS = 4
)
(
	input  logic        DIV_CLK,
	input  logic        reset,
	input  logic        frame_tick_i,
	ctrl_if.execute     ctrl,
	input  logic        spawn_valid_i,
	input  coord_t      spawn_x_i,
	input  level_t      level_i,
	input  logic        hit_ack_i,
	output logic        hit_req_o,
	output game_state_t state_o,
	output coord_t      jet_x_o,
	output coord_t      jet_y_o,
	output logic        playing_o
);

	localparam int IDX_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

	logic                 frame_q;      // Frame work one cycle after tick
	logic                 frame_play;
	logic                 fire_pend;    // Fire held until next frame
	logic [IDX_W-1:0]     blt_idx;
	logic [IDX_W-1:0]     ast_idx;
	coord_t               blt_x [NUM_SLOTS];
	coord_t               blt_y [NUM_SLOTS];   // Zero means slot free
	coord_t               ast_x [NUM_SLOTS];
	coord_t               ast_y [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] ast_live;
	logic [NUM_SLOTS-1:0] blt_hit;
	logic [NUM_SLOTS-1:0] ast_hit;
	int                   hit_cnt;
	int                   pend_sum;
	logic                 jet_hit;
	logic [2:0]           pend;         // Hits waiting for the handshake
	coord_t               fall_step;
	logic signed [11:0]   nx;
	logic signed [11:0]   ny;

	function automatic coord_t abs_diff(input coord_t p, input coord_t q);
		return (p > q) ? p - q : q - p;
	endfunction

	assign frame_play = frame_q && state_o == PLAY;
	assign playing_o  = state_o == PLAY;
	assign fall_step  = {8'd0, level_i} + 10'd1;

	// Candidate jet position
	assign nx = $signed({2'b00, jet_x_o}) + 12'(ctrl.step_x);
	assign ny = $signed({2'b00, jet_y_o}) + 12'(ctrl.step_y);

	//////////////////////////////
	// Collisions, old positions
	//////////////////////////////
	always_comb
	begin
		blt_hit = '0;
		ast_hit = '0;
		hit_cnt = 0;
		jet_hit = 1'b0;
		// One asteroid per bullet, first match wins
		for (int b = 0; b < NUM_SLOTS; b++)
		begin
			for (int a = 0; a < NUM_SLOTS; a++)
			begin
				if (blt_y[b] != '0 && ast_live[a] && !blt_hit[b] && !ast_hit[a]
					&& abs_diff(blt_x[b], ast_x[a]) <= HIT_HALF_WIDTH
					&& {1'b0, blt_y[b]} <= {1'b0, ast_y[a]} + 11'(BULLET_REACH))
				begin
					blt_hit[b] = 1'b1;
					ast_hit[a] = 1'b1;
					hit_cnt    = hit_cnt + 1;
				end
			end
		end
		for (int a = 0; a < NUM_SLOTS; a++)
		begin
			if (ast_live[a] && !ast_hit[a]
				&& abs_diff(ast_x[a], jet_x_o) <= HIT_HALF_WIDTH
				&& {1'b0, ast_y[a]} <= {1'b0, jet_y_o} + 11'(JET_HIT_DEPTH)
				&& jet_y_o <= ast_y[a])
				jet_hit = 1'b1;
		end
		// Pending count, saturated below
		pend_sum = int'(pend) + (frame_play ? hit_cnt : 0)
			- ((hit_req_o && hit_ack_i) ? 1 : 0);
	end

	//////////////////////////////
	// Control state
	//////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			frame_q   <= 1'b0;
			state_o   <= PAUSE;
			jet_x_o   <= JET_X_RESET;
			jet_y_o   <= JET_Y_RESET;
			fire_pend <= 1'b0;
			blt_idx   <= '0;
			ast_idx   <= '0;
			ast_live  <= '0;
			pend      <= '0;
			hit_req_o <= 1'b0;
			for (int b = 0; b < NUM_SLOTS; b++)
				blt_y[b] <= '0;
		end
		else
		begin
			frame_q   <= frame_tick_i;
			fire_pend <= (ctrl.fire && state_o == PLAY) || (fire_pend && !frame_play);
			pend      <= (pend_sum > 7) ? 3'd7 : 3'(pend_sum);   // Extra hits dropped

			// Four phase request, next one only after ack low
			if (hit_req_o && hit_ack_i)
				hit_req_o <= 1'b0;
			else if (!hit_req_o && !hit_ack_i && pend != '0)
				hit_req_o <= 1'b1;

			if (frame_q && state_o != GAMEOVER)
			begin
				if (state_o == PLAY && jet_hit)
					state_o <= GAMEOVER;         // Sticky until reset
				else
					state_o <= ctrl.run ? PLAY : PAUSE;
			end

			if (frame_play)
			begin
				// Jet only moves inside its box
				if (nx >= $signed({2'b00, JET_X_MIN}) && nx <= $signed({2'b00, JET_X_MAX}))
					jet_x_o <= nx[9:0];
				if (ny >= $signed({2'b00, JET_Y_MIN}) && ny <= $signed({2'b00, JET_Y_MAX}))
					jet_y_o <= ny[9:0];

				for (int b = 0; b < NUM_SLOTS; b++)
				begin
					if (blt_hit[b] || blt_y[b] <= {6'd0, ctrl.bullet_speed} + 10'd3)
						blt_y[b] <= '0;                   // Top reached or hit
					else
						blt_y[b] <= blt_y[b] - {6'd0, ctrl.bullet_speed};
				end
				if (fire_pend)
				begin
					blt_y[blt_idx] <= jet_y_o - 10'd3;   // Just above the nose
					blt_idx        <= (blt_idx == IDX_W'(NUM_SLOTS - 1)) ? '0 : blt_idx + 1'b1;
				end

				for (int a = 0; a < NUM_SLOTS; a++)
				begin
					if (ast_hit[a] || ast_y[a] + fall_step > ASTEROID_FLOOR)
						ast_live[a] <= 1'b0;
				end
				if (spawn_valid_i)
				begin
					ast_live[ast_idx] <= 1'b1;           // Overwrites oldest slot
					ast_idx           <= (ast_idx == IDX_W'(NUM_SLOTS - 1)) ? '0 : ast_idx + 1'b1;
				end
			end
		end
	end

	// Slot payload
	always_ff @(posedge DIV_CLK)
	begin
		if (frame_play)
		begin
			for (int a = 0; a < NUM_SLOTS; a++)
			begin
				if (ast_live[a])
					ast_y[a] <= ast_y[a] + fall_step;   // Faster at higher level
			end
			if (fire_pend)
				blt_x[blt_idx] <= jet_x_o;
			if (spawn_valid_i)
			begin
				ast_x[ast_idx] <= spawn_x_i;
				ast_y[ast_idx] <= '0;
			end
		end
	end

endmodule

/* design/score_keeper.sv */
module score_keeper
	import asteroid_pkg::*;
#(
	parameter int LEVEL_FRAMES = 1300
)
(
	input  logic   DIV_CLK,
	input  logic   reset,
	input  logic   frame_tick_i,
	input  logic   hit_req_i,
	input  logic   playing_i,
	output logic   hit_ack_o,
	output score_t score_o,
	output level_t level_o
);

	localparam int CNT_W = (LEVEL_FRAMES > 1) ? $clog2(LEVEL_FRAMES) : 1;

	logic [CNT_W-1:0] lvl_cnt;   // PLAY frames in this level

	//////////////////////////////
	// Hit handshake and score
	//////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			hit_ack_o <= 1'b0;
			score_o   <= '0;
		end
		else
		begin
			if (hit_req_i && !hit_ack_o)
			begin
				hit_ack_o <= 1'b1;
				score_o   <= score_o + 8'd1;   // Wraps at 255
			end
			else if (!hit_req_i)
				hit_ack_o <= 1'b0;             // Release after req drops
		end
	end

	//////////////////////////////
	// Level progression
	//////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			lvl_cnt <= '0;
			level_o <= '0;
		end
		else if (frame_tick_i && playing_i && level_o != 2'd3)
		begin
			// Top level holds, counter stops there
			if (lvl_cnt == CNT_W'(LEVEL_FRAMES - 1))
			begin
				lvl_cnt <= '0;
				level_o <= level_o + 2'd1;
			end
			else
				lvl_cnt <= lvl_cnt + 1'b1;
		end
	end

endmodule

/* design/asteroid_top.sv */
module asteroid_top
	import asteroid_pkg::*;
#(
	parameter int NUM_SLOTS    = 4,
	parameter int LEVEL_FRAMES = 1300
)
(
	input  logic        DIV_CLK,
	input  logic        reset,
	input  logic        frame_tick_i,
	input  logic        btn_fire_i,
	input  logic        btn_up_i,
	input  logic        btn_down_i,
	input  logic        btn_run_i,
	input  coord_t      joy_x_i,
	input  coord_t      joy_y_i,
	output game_state_t state_o,
	output coord_t      jet_x_o,
	output coord_t      jet_y_o,
	output score_t      score_o,
	output logic [7:0]  led_o
);

	ctrl_if ctrl_bus ();

	logic   spawn_valid;
	coord_t spawn_x;
	logic   playing;
	level_t level;
	logic   hit_req;
	logic   hit_ack;

	// Buttons and joystick to commands
	input_decode u_decode
	(
		.DIV_CLK    (DIV_CLK),
		.reset      (reset),
		.btn_fire_i (btn_fire_i),
		.btn_up_i   (btn_up_i),
		.btn_down_i (btn_down_i),
		.btn_run_i  (btn_run_i),
		.joy_x_i    (joy_x_i),
		.joy_y_i    (joy_y_i),
		.ctrl       (ctrl_bus.decode)
	);

	asteroid_spawner u_spawner
	(
		.DIV_CLK       (DIV_CLK),
		.reset         (reset),
		.frame_tick_i  (frame_tick_i),
		.playing_i     (playing),
		.level_i       (level),
		.spawn_valid_o (spawn_valid),
		.spawn_x_o     (spawn_x)
	);

	world_update #(.NUM_SLOTS(NUM_SLOTS)) u_world
	(
		.DIV_CLK       (DIV_CLK),
		.reset         (reset),
		.frame_tick_i  (frame_tick_i),
		.ctrl          (ctrl_bus.execute),
		.spawn_valid_i (spawn_valid),
		.spawn_x_i     (spawn_x),
		.level_i       (level),
		.hit_ack_i     (hit_ack),
		.hit_req_o     (hit_req),
		.state_o       (state_o),
		.jet_x_o       (jet_x_o),
		.jet_y_o       (jet_y_o),
		.playing_o     (playing)
	);

	score_keeper #(.LEVEL_FRAMES(LEVEL_FRAMES)) u_score
	(
		.DIV_CLK      (DIV_CLK),
		.reset        (reset),
		.frame_tick_i (frame_tick_i),
		.hit_req_i    (hit_req),
		.playing_i    (playing),
		.hit_ack_o    (hit_ack),
		.score_o      (score_o),
		.level_o      (level)
	);

	// High nibble one-hot level, low nibble bullet speed
	assign led_o = {4'b0001 << level, ctrl_bus.bullet_speed};

endmodule

/* verif/tb_clock_gen.sv */
module tb_clock_gen
(
	input  logic restart_i,   // Request a fresh reset
	output logic clk_o,
	output logic reset_o
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [3:0] rst_cnt = 4'd10;   // Reset cycles left

	initial
		clk_o = 1'b0;

	always
		#5 clk_o = ~clk_o;           // 10 ns period

	always @(posedge clk_o)
	begin
		if (restart_i)
			rst_cnt <= 4'd10;
		else if (rst_cnt != 4'd0)
			rst_cnt <= rst_cnt - 4'd1;
	end

	assign reset_o = (rst_cnt != 4'd0);

endmodule

/* verif/asteroid_assertions.sv */
module asteroid_assertions
	import asteroid_pkg::*;
(
	input logic        clk_i,
	input logic        reset_i,
	input logic        hit_req_i,
	input logic        hit_ack_i,
	input game_state_t state_i
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt = 0;   // Assertion failures so far

	// Request held until answered
	req_held: assert property (@(posedge clk_i) disable iff (reset_i)
		hit_req_i && !hit_ack_i |=> hit_req_i)
		else
		begin
			$error("hit_req dropped before hit_ack");
			fail_cnt = fail_cnt + 1;
		end

	// Ack only rises on a live request
	ack_on_req: assert property (@(posedge clk_i) disable iff (reset_i)
		$rose(hit_ack_i) |-> $past(hit_req_i))
		else
		begin
			$error("hit_ack raised without hit_req");
			fail_cnt = fail_cnt + 1;
		end

	// Sticky end state
	gameover_kept: assert property (@(posedge clk_i) disable iff (reset_i)
		state_i == GAMEOVER |=> state_i == GAMEOVER)
		else
		begin
			$error("GAMEOVER left without reset");
			fail_cnt = fail_cnt + 1;
		end

endmodule

/* verif/asteroid_tb.sv */
module asteroid_tb
	import asteroid_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int LVL_FRAMES = 20;
	// Frame budget per test, from the loop guards
	localparam int TOTAL_FRAMES = 5 + 90 + 20 + 90 + 330 + 460;

	logic        clk;
	logic        reset;
	logic        restart;
	logic        frame_tick_i;
	logic        btn_fire_i;
	logic        btn_up_i;
	logic        btn_down_i;
	logic        btn_run_i;
	coord_t      joy_x_i;
	coord_t      joy_y_i;
	game_state_t state_o;
	coord_t      jet_x_o;
	coord_t      jet_y_o;
	score_t      score_o;
	logic [7:0]  led_o;
	logic [1:0]  phase;

	// Reference model of spawner and level
	coord_t      lfsr_m;
	int          spawn_frames_m;
	int          level_frames_m;
	int          level_m;
	int          spawns_seen;
	coord_t      first_col;

	tb_clock_gen u_clk (.restart_i(restart), .clk_o(clk), .reset_o(reset));

	asteroid_top #(.NUM_SLOTS(4), .LEVEL_FRAMES(LVL_FRAMES)) u_dut
	(
		.DIV_CLK(clk), .reset(reset), .frame_tick_i(frame_tick_i),
		.btn_fire_i(btn_fire_i), .btn_up_i(btn_up_i), .btn_down_i(btn_down_i),
		.btn_run_i(btn_run_i), .joy_x_i(joy_x_i), .joy_y_i(joy_y_i),
		.state_o(state_o), .jet_x_o(jet_x_o), .jet_y_o(jet_y_o),
		.score_o(score_o), .led_o(led_o)
	);

	bind world_update asteroid_assertions u_assertions
	(
		.clk_i(DIV_CLK), .reset_i(reset), .hit_req_i(hit_req_o),
		.hit_ack_i(hit_ack_i), .state_i(state_o)
	);

	//////////////////////////////
	// Frame ticks and model
	//////////////////////////////
	always @(posedge clk)
	begin
		if (reset)
		begin
			phase        <= '0;
			frame_tick_i <= 1'b0;
		end
		else
		begin
			phase        <= phase + 2'd1;
			frame_tick_i <= (phase == 2'd3);   // One pulse every 4 clocks
		end
	end

	function automatic coord_t lfsr_next(input coord_t v);
		return {v[8:0], v[9] ^ v[6]};           // Taps 10 and 7
	endfunction

	function automatic coord_t column_of(input coord_t v);
		if (v > 10'd620)
			return v >> 1;
		return v + 10'd20;
	endfunction

	always @(posedge clk)
	begin
		if (reset)
		begin
			lfsr_m         <= LFSR_SEED;
			spawn_frames_m <= 0;
			level_frames_m <= 0;
			level_m        <= 0;
			spawns_seen    <= 0;
		end
		else if (frame_tick_i)
		begin
			lfsr_m <= lfsr_next(lfsr_m);     // Steps in any state
			if (state_o == PLAY)
			begin
				if (spawn_frames_m + 1 >= SPAWN_BASE - level_m * SPAWN_STEP)
				begin
					spawn_frames_m <= 0;
					spawns_seen    <= spawns_seen + 1;
					if (spawns_seen == 0)
						first_col <= column_of(lfsr_m);
				end
				else
					spawn_frames_m <= spawn_frames_m + 1;
				if (level_m != 3)
				begin
					if (level_frames_m == LVL_FRAMES - 1)
					begin
						level_frames_m <= 0;
						level_m        <= level_m + 1;
					end
					else
						level_frames_m <= level_frames_m + 1;
				end
			end
		end
	end

	//////////////////////////////
	// Checks and helpers
	//////////////////////////////
	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Run stopped");
	endtask

	task automatic value_error(input string what, input int got, input int exp);
		stop_with_failure($sformatf("[ERROR] %0d ns: %s is %0d, expected %0d",
			$time, what, got, exp));
	endtask

	task automatic check_state(input game_state_t got, input game_state_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %0d ns: state is %s, expected %s",
				$time, got.name(), exp.name()));
	endtask

	task automatic check_coord(input string what, input coord_t got, input coord_t exp);
		if (got !== exp)
			value_error(what, int'(got), int'(exp));
	endtask

	task automatic check_score(input score_t got, input score_t exp);
		if (got !== exp)
			value_error("score", int'(got), int'(exp));
	endtask

	task automatic check_led(input logic [7:0] got, input level_t level, input bspeed_t speed);
		logic [7:0] exp;
		exp            = {4'b0000, speed};   // Speed nibble
		exp[4 + level] = 1'b1;               // Level bit in the high nibble
		if (got !== exp)
			value_error("led_o", int'(got), int'(exp));
	endtask

	// Checker failures end the run
	always @(posedge clk)
	begin
		if (u_dut.u_world.u_assertions.fail_cnt != 0)
			stop_with_failure("A bound assertion on the hit handshake or state failed");
	end

	// Returns at a falling edge once the n-th frame has been applied
	task automatic wait_frames(input int n);
		repeat (n)
		begin
			@(posedge clk);
			while (frame_tick_i !== 1'b1)
				@(posedge clk);
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic press_button(input int which);
		@(posedge clk);
		case (which)
			0: btn_fire_i <= 1'b1;
			1: btn_up_i   <= 1'b1;
			2: btn_down_i <= 1'b1;
			default: btn_run_i <= 1'b1;
		endcase
		repeat (2) @(posedge clk);
		btn_fire_i <= 1'b0;
		btn_up_i   <= 1'b0;
		btn_down_i <= 1'b0;
		btn_run_i  <= 1'b0;
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic restart_game();
		@(posedge clk);
		joy_x_i <= 10'd500;                 // Dead zone
		joy_y_i <= 10'd500;
		restart <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		@(negedge clk);
		while (reset)
			@(negedge clk);
	endtask

	task automatic start_play();
		int guard;
		press_button(3);
		guard = 0;
		while (state_o != PLAY && guard < 40)
		begin
			@(negedge clk);
			guard++;
		end
		if (state_o != PLAY)
			stop_with_failure("Game did not enter PLAY after the run button");
	endtask

	task automatic wait_first_spawn();
		int guard;
		guard = 0;
		while (spawns_seen == 0 && guard < 100)
		begin
			wait_frames(1);
			guard++;
		end
		if (spawns_seen == 0)
			stop_with_failure("No asteroid spawn predicted in time");
	endtask

	// Walks the jet to a column, zone steps chosen from the distance
	task automatic steer_to(input coord_t target);
		int guard;
		int d;
		guard = 0;
		while (jet_x_o != target && guard < 150)
		begin
			d = int'(target) - int'(jet_x_o);
			@(posedge clk);
			if (d > 4)
				joy_x_i <= 10'd100;
			else if (d > 0)
				joy_x_i <= 10'd400;
			else if (d < -4)
				joy_x_i <= 10'd800;
			else
				joy_x_i <= 10'd600;
			wait_frames(1);
			guard++;
		end
		if (jet_x_o != target)
			stop_with_failure("Jet never reached the asteroid column");
		@(posedge clk);
		joy_x_i <= 10'd500;
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic test_reset();
		check_state(state_o, PAUSE);
		check_coord("jet_x", jet_x_o, JET_X_RESET);
		check_coord("jet_y", jet_y_o, JET_Y_RESET);
		check_score(score_o, 8'd0);
		check_led(led_o, 0, BSPEED_RESET);
	endtask

	task automatic test_steering();
		coord_t ex;
		coord_t ey;
		restart_game();
		@(posedge clk);
		joy_x_i <= 10'd100;                 // +4 right
		joy_y_i <= 10'd800;                 // +2 down
		wait_frames(3);
		check_coord("jet_x in PAUSE", jet_x_o, JET_X_RESET);
		check_coord("jet_y in PAUSE", jet_y_o, JET_Y_RESET);
		start_play();
		ex = JET_X_RESET;
		ey = JET_Y_RESET;
		for (int i = 0; i < 70; i++)
		begin
			if (ex + 10'd4 <= JET_X_MAX)
				ex = ex + 10'd4;
			if (ey + 10'd2 <= JET_Y_MAX)
				ey = ey + 10'd2;
			wait_frames(1);
			check_coord("jet_x", jet_x_o, ex);
			check_coord("jet_y", jet_y_o, ey);
		end
	endtask

	task automatic test_bullet_speed();
		bspeed_t exp;
		restart_game();
		exp = BSPEED_RESET;
		repeat (5)
		begin
			press_button(1);
			if (exp < BSPEED_MAX)
				exp = exp + 4'd1;
			check_led(led_o, 0, exp);
		end
		repeat (8)
		begin
			press_button(2);
			if (exp > BSPEED_MIN)
				exp = exp - 4'd1;
			check_led(led_o, 0, exp);
		end
	endtask

	task automatic test_level();
		restart_game();
		start_play();
		wait_frames(LVL_FRAMES - 1);
		check_led(led_o, 0, BSPEED_RESET);
		wait_frames(1);
		check_led(led_o, 1, BSPEED_RESET);
		wait_frames(2 * LVL_FRAMES);
		check_led(led_o, 3, BSPEED_RESET);
		wait_frames(LVL_FRAMES);
		check_led(led_o, 3, BSPEED_RESET);  // Top level holds
	endtask

	task automatic test_shooting();
		int guard;
		restart_game();
		start_play();
		wait_first_spawn();
		steer_to((first_col > JET_X_MAX) ? JET_X_MAX : first_col);
		press_button(0);
		guard = 0;
		while (score_o == 8'd0 && guard < 80)
		begin
			wait_frames(1);
			guard++;
		end
		check_score(score_o, 8'd1);
		check_state(state_o, PLAY);
	endtask

	task automatic test_game_over();
		int guard;
		coord_t jx;
		coord_t jy;
		restart_game();
		start_play();
		@(posedge clk);
		joy_y_i <= 10'd800;                 // Down to the bottom limit
		wait_first_spawn();
		steer_to((first_col > JET_X_MAX) ? JET_X_MAX : first_col);
		guard = 0;
		while (state_o != GAMEOVER && guard < 200)
		begin
			wait_frames(1);
			guard++;
		end
		check_state(state_o, GAMEOVER);
		jx = jet_x_o;
		jy = jet_y_o;
		@(posedge clk);
		joy_x_i <= 10'd100;
		joy_y_i <= 10'd200;
		press_button(0);
		press_button(3);
		wait_frames(5);
		check_state(state_o, GAMEOVER);
		check_coord("jet_x frozen", jet_x_o, jx);
		check_coord("jet_y frozen", jet_y_o, jy);
		check_score(score_o, 8'd0);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial
	begin
		restart      = 1'b0;
		frame_tick_i = 1'b0;
		btn_fire_i   = 1'b0;
		btn_up_i     = 1'b0;
		btn_down_i   = 1'b0;
		btn_run_i    = 1'b0;
		joy_x_i      = 10'd500;
		joy_y_i      = 10'd500;
		@(negedge clk);
		while (reset)
			@(negedge clk);
		test_reset();
		test_steering();
		test_bullet_speed();
		test_level();
		test_shooting();
		test_game_over();
		if (u_dut.u_world.u_assertions.fail_cnt == 0)
		begin
			$display("TEST PASSED");
			$finish;
		end
		else
			stop_with_failure("A bound assertion failed during the run");
	end

	// Watchdog sized from the frame budget, 40 ns per frame
	initial
	begin
		#(TOTAL_FRAMES * 40 + 2000);
		stop_with_failure("Watchdog expired before the tests finished");
	end

endmodule

/* build.f */
common/asteroid_pkg.sv
common/ctrl_if.sv
design/input_decode.sv
game/asteroid_spawner.sv
game/world_update.sv
design/score_keeper.sv
design/asteroid_top.sv
verif/tb_clock_gen.sv
verif/asteroid_assertions.sv
verif/asteroid_tb.sv

/* Bender.yml */
package:
  name: asteroid_game

sources:
  - common/asteroid_pkg.sv
  - common/ctrl_if.sv
  - design/input_decode.sv
  - game/asteroid_spawner.sv
  - game/world_update.sv
  - design/score_keeper.sv
  - design/asteroid_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/asteroid_assertions.sv
      - verif/asteroid_tb.sv
